//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = operand_core_tb
FILELIST  = src.f
RUN_FLAGS = +verilator+error+limit+1000
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

SOURCES   = $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/operand_core_chk.sv
// ****************************************************************************
// operand core assertions
// bubble after a stalled edge, quiet retire port out of reset and
// MEM forward priority over WB
// ****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module operand_core_chk (
    input wire                    clk,
    input wire                    arst_n,
    input wire                    ifu_valid, mem_rvalid, mem_wready,
    input wire                    wb_valid, wb_write_gpr, wb_write_csr, mem_req,
    input wire isa_pkg::gpr_idx_t ex_rs1, ex_rs2, mem_rd,
    input wire isa_pkg::csr_idx_t ex_csr_rs, mem_csr_rd,
    input wire                    mem_write_gpr, mem_write_csr, mem_mem_to_reg,
    input wire isa_pkg::word_t    ex_rs1_data, ex_rs2_data, ex_csr_data,
    input wire isa_pkg::word_t    mem_out, mem_alu_out, mem_csr_out
);
    int assert_fails = 0;

    assert property (@(posedge clk) disable iff (!arst_n)
        !(ifu_valid && mem_rvalid && mem_wready) |=> !wb_valid)
    else begin
        $error("wb_valid high after a stalled edge");
        assert_fails = assert_fails + 1;
    end

    assert property (@(posedge clk)
        $rose(arst_n) |-> !wb_valid && !wb_write_gpr && !wb_write_csr && !mem_req)
    else begin
        $error("retire port or memory request active out of reset");
        assert_fails = assert_fails + 1;
    end

    // a MEM hit must be the only term in the and-or select
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_write_gpr && ex_rs1 == mem_rd |->
            ex_rs1_data == (mem_mem_to_reg ? mem_out : mem_alu_out))
    else begin
        $error("rs1 forward mixes MEM and WB sources");
        assert_fails = assert_fails + 1;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_write_gpr && ex_rs2 == mem_rd |->
            ex_rs2_data == (mem_mem_to_reg ? mem_out : mem_alu_out))
    else begin
        $error("rs2 forward mixes MEM and WB sources");
        assert_fails = assert_fails + 1;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_write_csr && ex_csr_rs == mem_csr_rd |-> ex_csr_data == mem_csr_out)
    else begin
        $error("csr forward mixes MEM and WB sources");
        assert_fails = assert_fails + 1;
    end

endmodule

bind operand_core operand_core_chk u_chk (.*);

`default_nettype wire

//--- bench/operand_core_tb.sv
// ****************************************************************************
// operand core testbench
// clock and reset, random decoded instruction stream with random stall
// levels, load data responder, cycle limit and the closing summary
// ****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module operand_core_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int    NUM_INSTR     = 400;
    localparam int    MAX_CYCLES    = NUM_INSTR * 8 + 50;
    localparam word_t RDATA_PATTERN = 32'h5a3c_96e1;

    logic     clk;
    logic     arst_n;
    op_kind_t id_op = OP_NONE;
    gpr_idx_t id_rs1 = '0, id_rs2 = '0, id_rd = '0;
    csr_idx_t id_csr_rs = '0, id_csr_rd = '0;
    logic     ifu_valid = 1'b1;
    logic     mem_wready = 1'b1;
    logic     mem_rvalid;
    word_t    mem_rdata = '0;
    word_t    mem_addr, wb_gpr_data, wb_csr_data;
    logic     mem_req, wb_valid, wb_write_gpr, wb_write_csr;
    gpr_idx_t wb_rd;
    csr_idx_t wb_csr_rd;
    logic     advance;

    // responder state
    logic     resp_valid = 1'b0;
    logic     req_seen = 1'b0;
    int       resp_wait = 0;

    int       seed = 77;
    int       sent = 0;
    int       cycles = 0;
    int       total;
    int       retired, mismatches;

    operand_core DUT (.*);

    wb_monitor #(.RDATA_PATTERN(RDATA_PATTERN)) u_monitor (.*);

    // mostly x0..x3 so that operands collide often
    function automatic gpr_idx_t biased_gpr(input int r);
        if (r[4:2] != 3'd0) begin
            biased_gpr = {3'b000, r[1:0]};
        end else begin
            biased_gpr = r[9:5];
        end
    endfunction

    function automatic op_kind_t weighted_op(input int r);
        case (r[2:0])
            3'd0, 3'd1, 3'd2: weighted_op = OP_ALU;
            3'd3, 3'd4:       weighted_op = OP_CSR;
            default:          weighted_op = OP_LOAD;
        endcase
    endfunction

    task automatic drive_next_instr();
        id_op     <= weighted_op($random(seed));
        id_rs1    <= biased_gpr($random(seed));
        id_rs2    <= biased_gpr($random(seed));
        id_rd     <= biased_gpr($random(seed));
        id_csr_rs <= csr_idx_t'($unsigned($random(seed)) % 4);
        id_csr_rd <= csr_idx_t'($unsigned($random(seed)) % 4);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    end

    assign advance = ifu_valid && mem_rvalid && mem_wready;

    // fields stay put until the pipe takes them
    always @(posedge clk) begin
        if (arst_n) begin
            ifu_valid  <= ($unsigned($random(seed)) % 100) >= 15;
            mem_wready <= ($unsigned($random(seed)) % 100) >= 15;
            if (advance || id_op == OP_NONE) begin
                if (sent < NUM_INSTR) begin
                    drive_next_instr();
                    sent <= sent + 1;
                end else begin
                    id_op <= OP_NONE;
                end
            end
        end
    end

    // data valid drops as soon as a load shows up in MEM
    assign mem_rvalid = !mem_req || resp_valid;

    always @(posedge clk) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
            req_seen   <= 1'b0;
        end else if (mem_req && resp_valid) begin
            if (ifu_valid && mem_wready) begin
                resp_valid <= 1'b0;
                req_seen   <= 1'b0;
            end
        end else if (mem_req) begin
            if (!req_seen) begin
                req_seen  <= 1'b1;
                resp_wait <= $unsigned($random(seed)) % 4;
            end else if (resp_wait == 0) begin
                resp_valid <= 1'b1;
                mem_rdata  <= mem_addr ^ RDATA_PATTERN;
            end else begin
                resp_wait <= resp_wait - 1;
            end
        end
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout after %0d cycles, %0d of %0d instructions retired",
                 cycles, retired, NUM_INSTR);
        $display("test failed");
        $finish;
    end

    initial begin
        wait (arst_n === 1'b1);
        wait (retired == NUM_INSTR);
        // a few more cycles to catch stray retirements
        repeat (10) @(posedge clk);
        total = mismatches + DUT.u_chk.assert_fails;
        $display("errors %0d: %0d mismatches, %0d assertion failures, %0d retired",
                 total, mismatches, DUT.u_chk.assert_fails, retired);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/wb_monitor.sv
// ****************************************************************************
// retire monitor
// queues every instruction taken at ID and checks each retirement
// against an architectural GPR and CSR model
// ****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module wb_monitor #(
    parameter isa_pkg::word_t RDATA_PATTERN = '0
) (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     ifu_valid,
    input  wire                     mem_rvalid,
    input  wire                     mem_wready,
    input  wire pipe_pkg::op_kind_t id_op,
    input  wire isa_pkg::gpr_idx_t  id_rs1, id_rs2, id_rd,
    input  wire isa_pkg::csr_idx_t  id_csr_rs, id_csr_rd,
    input  wire                     mem_req,
    input  wire isa_pkg::word_t     mem_addr,
    input  wire                     wb_valid, wb_write_gpr, wb_write_csr,
    input  wire isa_pkg::gpr_idx_t  wb_rd,
    input  wire isa_pkg::csr_idx_t  wb_csr_rd,
    input  wire isa_pkg::word_t     wb_gpr_data, wb_csr_data,
    output int                      retired,
    output int                      mismatches
);
    import isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        op_kind_t op;
        gpr_idx_t rs1;
        gpr_idx_t rs2;
        csr_idx_t csr_rs;
        gpr_idx_t rd;
        csr_idx_t csr_rd;
    } instr_t;

    instr_t pending_q [$];
    word_t  gpr_model [32];
    word_t  csr_model [4];
    int     retire_count = 0;
    int     err_count = 0;

    // memory request of the instruction that last moved from MEM to WB
    logic   left_mem_req = 1'b0;
    word_t  left_mem_addr = '0;

    assign retired    = retire_count;
    assign mismatches = err_count;

    function automatic string op_name(input op_kind_t op);
        case (op)
            OP_CSR:  op_name = "csr";
            OP_LOAD: op_name = "load";
            default: op_name = "alu";
        endcase
    endfunction

    task automatic check_field(input string name, input int seq, input word_t expected,
                               input word_t actual);
        if (expected !== actual) begin
            err_count = err_count + 1;
            $display("Mismatch %s, instr %0d: expected %h, actual %h",
                     name, seq, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        instr_t ins;
        word_t  exp_rd;
        word_t  new_csr;
        string  kind;
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                gpr_model[i] = '0;
            end
            for (int i = 0; i < 4; i++) begin
                csr_model[i] = '0;
            end
        end else begin
            if (wb_valid && pending_q.size() == 0) begin
                err_count = err_count + 1;
                $display("retirement seen with no instruction in flight");
            end else if (wb_valid) begin
                ins  = pending_q.pop_front();
                kind = op_name(ins.op);
                // operation rules on the state before this instruction
                new_csr = csr_model[ins.csr_rs] | gpr_model[ins.rs1];
                case (ins.op)
                    OP_CSR:  exp_rd = csr_model[ins.csr_rs];
                    OP_LOAD: exp_rd = (gpr_model[ins.rs1] + gpr_model[ins.rs2]) ^ RDATA_PATTERN;
                    default: exp_rd = gpr_model[ins.rs1] + gpr_model[ins.rs2];
                endcase
                check_field({kind, " mem request"}, retire_count,
                            word_t'(ins.op == OP_LOAD), word_t'(left_mem_req));
                if (ins.op == OP_LOAD) begin
                    check_field("load address", retire_count,
                                gpr_model[ins.rs1] + gpr_model[ins.rs2], left_mem_addr);
                end
                check_field({kind, " gpr write"}, retire_count,
                            word_t'(ins.rd != '0), word_t'(wb_write_gpr));
                check_field({kind, " csr write"}, retire_count,
                            word_t'(ins.op == OP_CSR), word_t'(wb_write_csr));
                if (ins.rd != '0) begin
                    check_field({kind, " rd index"}, retire_count, word_t'(ins.rd), word_t'(wb_rd));
                    check_field({kind, " rd value"}, retire_count, exp_rd, wb_gpr_data);
                    gpr_model[ins.rd] = exp_rd;
                end
                if (ins.op == OP_CSR) begin
                    check_field("csr index", retire_count, word_t'(ins.csr_rd), word_t'(wb_csr_rd));
                    check_field("csr value", retire_count, new_csr, wb_csr_data);
                    csr_model[ins.csr_rd] = new_csr;
                end
                retire_count = retire_count + 1;
            end
            if (ifu_valid && mem_rvalid && mem_wready) begin
                left_mem_req  = mem_req;
                left_mem_addr = mem_addr;
                if (id_op != OP_NONE) begin
                    pending_q.push_back({id_op, id_rs1, id_rs2, id_csr_rs, id_rd, id_csr_rd});
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/exec_stage.sv
// *************************************************************************
// execute stage
// operand selection against the forward unit, adder and csr update,
// EX-MEM register that holds under stall
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     stall_me,
    input  wire pipe_pkg::op_kind_t ex_op,
    input  wire isa_pkg::gpr_idx_t  ex_rd,
    input  wire isa_pkg::csr_idx_t  ex_csr_rd,
    input  wire                     ex_write_gpr,
    input  wire                     ex_write_csr,
    input  wire                     ex_mem_to_reg,
    input  wire isa_pkg::word_t     ex_rs1_val, ex_rs2_val, ex_csr_val,
    input  wire                     ex_rs1_hazard, ex_rs2_hazard, ex_csr_hazard,
    input  wire isa_pkg::word_t     ex_rs1_data, ex_rs2_data, ex_csr_data,
    output pipe_pkg::op_kind_t      mem_op,
    output isa_pkg::gpr_idx_t       mem_rd,
    output isa_pkg::csr_idx_t       mem_csr_rd,
    output logic                    mem_write_gpr,
    output logic                    mem_write_csr,
    output logic                    mem_mem_to_reg,
    output isa_pkg::word_t          mem_alu_out,
    output isa_pkg::word_t          mem_csr_out
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t op_rs1;
    word_t op_rs2;
    word_t op_csr;
    word_t sum;

    // forwarded value wins over the segment copy
    assign op_rs1 = ex_rs1_hazard ? ex_rs1_data : ex_rs1_val;
    assign op_rs2 = ex_rs2_hazard ? ex_rs2_data : ex_rs2_val;
    assign op_csr = ex_csr_hazard ? ex_csr_data : ex_csr_val;

    // alu result and load address
    assign sum = op_rs1 + op_rs2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_op         <= OP_NONE;
            mem_write_gpr  <= 1'b0;
            mem_write_csr  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
        end else if (!stall_me) begin
            mem_op         <= ex_op;
            mem_write_gpr  <= ex_write_gpr;
            mem_write_csr  <= ex_write_csr;
            mem_mem_to_reg <= ex_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_me) begin
            mem_rd      <= ex_rd;
            mem_csr_rd  <= ex_csr_rd;
            // csr ops hand the old csr value to rd
            mem_alu_out <= (ex_op == OP_CSR) ? op_csr : sum;
            mem_csr_out <= op_csr | op_rs1;
        end
    end

endmodule

`default_nettype wire

//--- design/hazard_forward.sv
// *************************************************************************
// hazard and forward unit
// global stall and flush from the three stall levels, plus forward
// selection towards EX (MEM and WB sources) and the ID-EX register (WB)
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "pipe_consts.svh"

module hazard_forward (
    input  wire                    ifu_valid,
    input  wire                    mem_rvalid,
    input  wire                    mem_wready,
    input  wire isa_pkg::gpr_idx_t id_rs1,
    input  wire isa_pkg::gpr_idx_t id_rs2,
    input  wire isa_pkg::csr_idx_t id_csr_rs,
    input  wire isa_pkg::gpr_idx_t ex_rs1,
    input  wire isa_pkg::gpr_idx_t ex_rs2,
    input  wire isa_pkg::csr_idx_t ex_csr_rs,
    input  wire                    mem_mem_to_reg,
    input  wire isa_pkg::gpr_idx_t mem_rd,
    input  wire isa_pkg::csr_idx_t mem_csr_rd,
    input  wire                    mem_write_gpr,
    input  wire                    mem_write_csr,
    input  wire isa_pkg::word_t    mem_out,
    input  wire isa_pkg::word_t    mem_alu_out,
    input  wire isa_pkg::word_t    mem_csr_out,
    input  wire isa_pkg::gpr_idx_t wb_rd,
    input  wire isa_pkg::csr_idx_t wb_csr_rd,
    input  wire                    wb_write_gpr,
    input  wire                    wb_write_csr,
    input  wire isa_pkg::word_t    wb_gpr_data,
    input  wire isa_pkg::word_t    wb_csr_data,
    output logic                   stall_if,
    output logic                   stall_id,
    output logic                   stall_me,
    output logic                   flush_wb,
    output logic                   ex_rs1_hazard, ex_rs2_hazard, ex_csr_hazard,
    output isa_pkg::word_t         ex_rs1_data, ex_rs2_data, ex_csr_data,
    output logic                   seg_rs1_hazard, seg_rs2_hazard, seg_csr_hazard,
    output isa_pkg::word_t         seg_rs1_data, seg_rs2_data, seg_csr_data
);
    logic advance;
    logic mem_hit_rs1, mem_hit_rs2, mem_hit_csr;
    logic first_rs1, first_rs2, first_csr;
    logic load_rs1, load_rs2;
    logic second_rs1, second_rs2, second_csr;

    // pipe moves only with fetch and both memory levels up
    assign advance  = ifu_valid & mem_rvalid & mem_wready;
    assign stall_if = ~advance;
    assign stall_id = ~advance;
    assign stall_me = ~advance;
    assign flush_wb = ~advance;

    // third stage: ID reads what WB writes this cycle
    assign seg_rs1_hazard = (id_rs1 == wb_rd) & wb_write_gpr;
    assign seg_rs2_hazard = (id_rs2 == wb_rd) & wb_write_gpr;
    assign seg_csr_hazard = (id_csr_rs == wb_csr_rd) & wb_write_csr;

    // EX source register written by the MEM instruction
    assign mem_hit_rs1 = (ex_rs1 == mem_rd) & mem_write_gpr;
    assign mem_hit_rs2 = (ex_rs2 == mem_rd) & mem_write_gpr;
    assign mem_hit_csr = (ex_csr_rs == mem_csr_rd) & mem_write_csr;

    // first stage from the ALU result, load-use from returned data
    assign first_rs1 = mem_hit_rs1 & ~mem_mem_to_reg;
    assign first_rs2 = mem_hit_rs2 & ~mem_mem_to_reg;
    assign load_rs1  = mem_hit_rs1 & mem_mem_to_reg;
    assign load_rs2  = mem_hit_rs2 & mem_mem_to_reg;
    // loads never write a csr
    assign first_csr = mem_hit_csr;

    // second stage, the younger MEM result shadows WB
    assign second_rs1 = (ex_rs1 == wb_rd) & wb_write_gpr & ~mem_hit_rs1;
    assign second_rs2 = (ex_rs2 == wb_rd) & wb_write_gpr & ~mem_hit_rs2;
    assign second_csr = (ex_csr_rs == wb_csr_rd) & wb_write_csr & ~mem_hit_csr;

    assign ex_rs1_hazard = second_rs1 | first_rs1 | load_rs1;
    assign ex_rs2_hazard = second_rs2 | first_rs2 | load_rs2;
    assign ex_csr_hazard = second_csr | first_csr;

    // and-or select, at most one term per operand
    assign ex_rs1_data = ({`XLEN{second_rs1}} & wb_gpr_data) |
                         ({`XLEN{load_rs1}}   & mem_out)     |
                         ({`XLEN{first_rs1}}  & mem_alu_out);
    assign ex_rs2_data = ({`XLEN{second_rs2}} & wb_gpr_data) |
                         ({`XLEN{load_rs2}}   & mem_out)     |
                         ({`XLEN{first_rs2}}  & mem_alu_out);
    assign ex_csr_data = ({`XLEN{second_csr}} & wb_csr_data) |
                         ({`XLEN{first_csr}}  & mem_csr_out);

    assign seg_rs1_data = {`XLEN{seg_rs1_hazard}} & wb_gpr_data;
    assign seg_rs2_data = {`XLEN{seg_rs2_hazard}} & wb_gpr_data;
    assign seg_csr_data = {`XLEN{seg_csr_hazard}} & wb_csr_data;

endmodule

`default_nettype wire

//--- design/id_ex_seg.sv
// *************************************************************************
// ID-EX segment register
// derives write enables from the op class, captures operands with the
// WB bypass on an advancing edge, refreshes forwarded operands on a stall
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module id_ex_seg (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     stall_id,
    input  wire pipe_pkg::op_kind_t id_op,
    input  wire isa_pkg::gpr_idx_t  id_rs1,
    input  wire isa_pkg::gpr_idx_t  id_rs2,
    input  wire isa_pkg::csr_idx_t  id_csr_rs,
    input  wire isa_pkg::gpr_idx_t  id_rd,
    input  wire isa_pkg::csr_idx_t  id_csr_rd,
    input  wire isa_pkg::word_t     rf_rs1_data, rf_rs2_data, rf_csr_data,
    input  wire                     seg_rs1_hazard, seg_rs2_hazard, seg_csr_hazard,
    input  wire isa_pkg::word_t     seg_rs1_data, seg_rs2_data, seg_csr_data,
    input  wire                     ex_rs1_hazard, ex_rs2_hazard, ex_csr_hazard,
    input  wire isa_pkg::word_t     ex_rs1_data, ex_rs2_data, ex_csr_data,
    output pipe_pkg::op_kind_t      ex_op,
    output isa_pkg::gpr_idx_t       ex_rs1,
    output isa_pkg::gpr_idx_t       ex_rs2,
    output isa_pkg::csr_idx_t       ex_csr_rs,
    output isa_pkg::gpr_idx_t       ex_rd,
    output isa_pkg::csr_idx_t       ex_csr_rd,
    output logic                    ex_write_gpr,
    output logic                    ex_write_csr,
    output logic                    ex_mem_to_reg,
    output isa_pkg::word_t          ex_rs1_val, ex_rs2_val, ex_csr_val
);
    import pipe_pkg::*;

    logic dec_write_gpr;
    logic dec_write_csr;
    logic dec_mem_to_reg;

    // every real op writes rd, a write to x0 dies here
    assign dec_write_gpr  = (id_op != OP_NONE) && (id_rd != '0);
    assign dec_write_csr  = (id_op == OP_CSR);
    assign dec_mem_to_reg = (id_op == OP_LOAD);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_op         <= OP_NONE;
            ex_write_gpr  <= 1'b0;
            ex_write_csr  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
        end else if (!stall_id) begin
            ex_op         <= id_op;
            ex_write_gpr  <= dec_write_gpr;
            ex_write_csr  <= dec_write_csr;
            ex_mem_to_reg <= dec_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_id) begin
            ex_rs1     <= id_rs1;
            ex_rs2     <= id_rs2;
            ex_csr_rs  <= id_csr_rs;
            ex_rd      <= id_rd;
            ex_csr_rd  <= id_csr_rd;
            ex_rs1_val <= seg_rs1_hazard ? seg_rs1_data : rf_rs1_data;
            ex_rs2_val <= seg_rs2_hazard ? seg_rs2_data : rf_rs2_data;
            ex_csr_val <= seg_csr_hazard ? seg_csr_data : rf_csr_data;
        end else begin
            // WB gets flushed on this edge, keep what it forwards now
            if (ex_rs1_hazard) begin
                ex_rs1_val <= ex_rs1_data;
            end
            if (ex_rs2_hazard) begin
                ex_rs2_val <= ex_rs2_data;
            end
            if (ex_csr_hazard) begin
                ex_csr_val <= ex_csr_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/isa_pkg.sv
// *************************************************************************
// isa types
// data word and register index types shared by all stages
// *************************************************************************
`default_nettype none

`include "pipe_consts.svh"

package isa_pkg;

    // architectural data word
    typedef logic [`XLEN-1:0]   word_t;

    // register file indices
    typedef logic [`GPR_AW-1:0] gpr_idx_t;
    typedef logic [`CSR_AW-1:0] csr_idx_t;

endpackage

`default_nettype wire

//--- design/mem_wb_stage.sv
// *************************************************************************
// memory and write-back stage
// load request outputs, load data take-up and the MEM-WB retire register
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module mem_wb_stage (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     flush_wb,
    input  wire pipe_pkg::op_kind_t mem_op,
    input  wire isa_pkg::gpr_idx_t  mem_rd,
    input  wire isa_pkg::csr_idx_t  mem_csr_rd,
    input  wire                     mem_write_gpr,
    input  wire                     mem_write_csr,
    input  wire                     mem_mem_to_reg,
    input  wire isa_pkg::word_t     mem_alu_out,
    input  wire isa_pkg::word_t     mem_csr_out,
    input  wire isa_pkg::word_t     mem_rdata,
    output logic                    mem_req,
    output isa_pkg::word_t          mem_addr,
    output isa_pkg::word_t          mem_out,
    output logic                    wb_valid,
    output logic                    wb_write_gpr,
    output isa_pkg::gpr_idx_t       wb_rd,
    output isa_pkg::word_t          wb_gpr_data,
    output logic                    wb_write_csr,
    output isa_pkg::csr_idx_t       wb_csr_rd,
    output isa_pkg::word_t          wb_csr_data
);
    import pipe_pkg::*;

    // request stays up until the load leaves MEM
    assign mem_req  = mem_mem_to_reg;
    assign mem_addr = mem_alu_out;
    assign mem_out  = mem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid     <= 1'b0;
            wb_write_gpr <= 1'b0;
            wb_write_csr <= 1'b0;
        end else begin
            // a flush turns the slot into a bubble
            wb_valid     <= !flush_wb && (mem_op != OP_NONE);
            wb_write_gpr <= !flush_wb && mem_write_gpr;
            wb_write_csr <= !flush_wb && mem_write_csr;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= mem_rd;
        wb_csr_rd   <= mem_csr_rd;
        wb_gpr_data <= mem_mem_to_reg ? mem_out : mem_alu_out;
        wb_csr_data <= mem_csr_out;
    end

endmodule

`default_nettype wire

//--- design/operand_core.sv
// *************************************************************************
// operand delivery core
// register files, ID-EX register, execute, memory/write-back and the
// hazard and forward unit tied into one pipeline slice
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module operand_core (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire pipe_pkg::op_kind_t id_op,
    input  wire isa_pkg::gpr_idx_t  id_rs1,
    input  wire isa_pkg::gpr_idx_t  id_rs2,
    input  wire isa_pkg::csr_idx_t  id_csr_rs,
    input  wire isa_pkg::gpr_idx_t  id_rd,
    input  wire isa_pkg::csr_idx_t  id_csr_rd,
    input  wire                     ifu_valid,
    input  wire                     mem_rvalid,
    input  wire                     mem_wready,
    input  wire isa_pkg::word_t     mem_rdata,
    output logic                    mem_req,
    output isa_pkg::word_t          mem_addr,
    output logic                    wb_valid,
    output logic                    wb_write_gpr,
    output isa_pkg::gpr_idx_t       wb_rd,
    output isa_pkg::word_t          wb_gpr_data,
    output logic                    wb_write_csr,
    output isa_pkg::csr_idx_t       wb_csr_rd,
    output isa_pkg::word_t          wb_csr_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // stall and flush
    logic     stall_id, stall_me, flush_wb;

    // ID read data and forward paths
    word_t    rf_rs1_data, rf_rs2_data, rf_csr_data;
    logic     seg_rs1_hazard, seg_rs2_hazard, seg_csr_hazard;
    word_t    seg_rs1_data, seg_rs2_data, seg_csr_data;
    logic     ex_rs1_hazard, ex_rs2_hazard, ex_csr_hazard;
    word_t    ex_rs1_data, ex_rs2_data, ex_csr_data;

    // EX stage fields
    op_kind_t ex_op;
    gpr_idx_t ex_rs1, ex_rs2, ex_rd;
    csr_idx_t ex_csr_rs, ex_csr_rd;
    logic     ex_write_gpr, ex_write_csr, ex_mem_to_reg;
    word_t    ex_rs1_val, ex_rs2_val, ex_csr_val;

    // MEM stage fields
    op_kind_t mem_op;
    gpr_idx_t mem_rd;
    csr_idx_t mem_csr_rd;
    logic     mem_write_gpr, mem_write_csr, mem_mem_to_reg;
    word_t    mem_alu_out, mem_csr_out, mem_out;

    reg_files u_reg_files (
        .clk       (clk),
        .arst_n    (arst_n),
        .rs1       (id_rs1),
        .rs2       (id_rs2),
        .csr_rs    (id_csr_rs),
        .rs1_data  (rf_rs1_data),
        .rs2_data  (rf_rs2_data),
        .csr_data  (rf_csr_data),
        .write_gpr (wb_write_gpr),
        .write_csr (wb_write_csr),
        .rd        (wb_rd),
        .csr_rd    (wb_csr_rd),
        .gpr_data  (wb_gpr_data),
        .csr_wdata (wb_csr_data)
    );

    id_ex_seg u_id_ex_seg (.*);

    // no fetch stage in this slice
    hazard_forward u_hazard_forward (
        .stall_if (),
        .*
    );

    exec_stage u_exec_stage (.*);

    mem_wb_stage u_mem_wb_stage (.*);

endmodule

`default_nettype wire

//--- design/pipe_consts.svh
// *************************************************************************
// pipeline constants
// data word width, register index widths and csr count
// *************************************************************************
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// data word
`define XLEN    32

// register file geometry
`define GPR_AW  5
`define CSR_AW  2
`define CSR_NUM 4

`endif

//--- design/pipe_pkg.sv
// *************************************************************************
// pipeline control types
// operation class carried down the pipe with its codes
// *************************************************************************
`default_nettype none

package pipe_pkg;

    // operation class, decoded before ID
    typedef logic [1:0] op_kind_t;

    // bubble
    localparam op_kind_t OP_NONE = 2'd0;
    localparam op_kind_t OP_ALU  = 2'd1;
    localparam op_kind_t OP_CSR  = 2'd2;
    localparam op_kind_t OP_LOAD = 2'd3;

endpackage

`default_nettype wire

//--- design/reg_files.sv
// *************************************************************************
// register files
// gpr file with x0 tied to zero and a small csr file,
// combinational reads in ID, writes from WB on the clock edge
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "pipe_consts.svh"

module reg_files (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire isa_pkg::gpr_idx_t rs1,
    input  wire isa_pkg::gpr_idx_t rs2,
    input  wire isa_pkg::csr_idx_t csr_rs,
    output isa_pkg::word_t         rs1_data,
    output isa_pkg::word_t         rs2_data,
    output isa_pkg::word_t         csr_data,
    input  wire                    write_gpr,
    input  wire                    write_csr,
    input  wire isa_pkg::gpr_idx_t rd,
    input  wire isa_pkg::csr_idx_t csr_rd,
    input  wire isa_pkg::word_t    gpr_data,
    input  wire isa_pkg::word_t    csr_wdata
);
    import isa_pkg::*;

    localparam int GPR_NUM = 1 << `GPR_AW;

    // x0 has no storage
    word_t gpr [1:GPR_NUM-1];
    word_t csr [`CSR_NUM];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < GPR_NUM; i++) begin
                gpr[i] <= '0;
            end
            for (int i = 0; i < `CSR_NUM; i++) begin
                csr[i] <= '0;
            end
        end else begin
            if (write_gpr && rd != '0) begin
                gpr[rd] <= gpr_data;
            end
            if (write_csr) begin
                csr[csr_rd] <= csr_wdata;
            end
        end
    end

    // same-cycle WB writes reach ID through the third-stage forward
    assign rs1_data = (rs1 == '0) ? '0 : gpr[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : gpr[rs2];
    assign csr_data = csr[csr_rs];

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_files.sv
design/id_ex_seg.sv
design/hazard_forward.sv
design/exec_stage.sv
design/mem_wb_stage.sv
design/operand_core.sv
bench/wb_monitor.sv
bench/operand_core_chk.sv
bench/operand_core_tb.sv
